// ==== common/buffer_settings.svh ====
// Credit buffer configuration
// Word width, FIFO geometry and downstream credit allowance

`ifndef BUFFER_SETTINGS_SVH
`define BUFFER_SETTINGS_SVH

// Width of one data word
`define BUF_DATA_WIDTH 8

// FIFO pointer width that sets the depth as a power of two
`define BUF_ADDR_WIDTH 4

// Number of FIFO entries and the upstream sender's starting credits
`define BUF_DEPTH (1 << `BUF_ADDR_WIDTH)

// Downstream credits held after reset
`define BUF_DOWN_CREDITS 4

`endif

// ==== common/buffer_pkg.sv ====
// Credit buffer types
// Word and pointer vectors, beat structs and the drain FSM states

`include "buffer_settings.svh"

package buffer_pkg;

  // One data word on either side of the buffer
  typedef logic [`BUF_DATA_WIDTH-1:0] word_t;

  // FIFO read and write pointers
  typedef logic [`BUF_ADDR_WIDTH-1:0] ptr_t;

  // Downstream credit count from 0 up to BUF_DOWN_CREDITS
  typedef logic [$clog2(`BUF_DOWN_CREDITS + 1)-1:0] credit_t;

  // Upstream write beat
  typedef struct packed {
    logic  valid;
    word_t data;
  } in_beat_t;

  // Downstream send beat
  typedef struct packed {
    logic  valid;
    word_t data;
  } out_beat_t;

  // Drain FSM states that say why the buffer is or is not sending
  typedef enum logic [1:0] {
    idle        = 2'd0,
    send        = 2'd1,
    wait_credit = 2'd2
  } drain_state_e;

endpackage

// ==== fifo/fifo.sv ====
// Register-file FIFO with pointer and flag registers
// An accepted read loads the head word into a registered output beat

`timescale 1ns/1ps

`include "buffer_settings.svh"

module fifo (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr,
  input  buffer_pkg::word_t    w_data,
  input  logic                 rd,
  output buffer_pkg::out_beat_t r_beat,
  output logic                 empty,
  output logic                 full
);

  // Storage
  buffer_pkg::word_t mem [`BUF_DEPTH];

  // Pointers and their successors
  buffer_pkg::ptr_t w_ptr_reg;
  buffer_pkg::ptr_t w_ptr_next;
  buffer_pkg::ptr_t w_ptr_succ;
  buffer_pkg::ptr_t r_ptr_reg;
  buffer_pkg::ptr_t r_ptr_next;
  buffer_pkg::ptr_t r_ptr_succ;

  // Status flags
  logic full_reg;
  logic full_next;
  logic empty_reg;
  logic empty_next;

  // Accepted operations
  logic wr_en;
  logic rd_en;

  // Read output register
  logic              r_valid_reg;
  buffer_pkg::word_t r_data_reg;

  assign wr_en = wr && !full_reg;
  assign rd_en = rd && !empty_reg;

  // Pointers wrap naturally since the depth is a power of two
  assign w_ptr_succ = w_ptr_reg + 1'b1;
  assign r_ptr_succ = r_ptr_reg + 1'b1;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[w_ptr_reg] <= w_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      r_data_reg <= mem[r_ptr_reg];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      w_ptr_reg   <= '0;
      r_ptr_reg   <= '0;
      full_reg    <= 1'b0;
      empty_reg   <= 1'b1;
      r_valid_reg <= 1'b0;
    end else begin
      w_ptr_reg   <= w_ptr_next;
      r_ptr_reg   <= r_ptr_next;
      full_reg    <= full_next;
      empty_reg   <= empty_next;
      r_valid_reg <= rd_en;
    end
  end

  // Flags follow the combination of accepted write and read
  always_comb begin
    w_ptr_next = w_ptr_reg;
    r_ptr_next = r_ptr_reg;
    full_next  = full_reg;
    empty_next = empty_reg;
    case ({wr_en, rd_en})
      2'b10: begin
        w_ptr_next = w_ptr_succ;
        empty_next = 1'b0;
        full_next  = (w_ptr_succ == r_ptr_reg);
      end
      2'b01: begin
        r_ptr_next = r_ptr_succ;
        full_next  = 1'b0;
        empty_next = (r_ptr_succ == w_ptr_reg);
      end
      2'b11: begin
        // Occupancy unchanged
        w_ptr_next = w_ptr_succ;
        r_ptr_next = r_ptr_succ;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    r_beat.valid = r_valid_reg;
    r_beat.data  = r_data_reg;
  end

  assign empty = empty_reg;
  assign full  = full_reg;

endmodule

// ==== src/credit_counter.sv ====
// Downstream credit counter
// Counts credits held, up on each return, down on each send

`timescale 1ns/1ps

`include "buffer_settings.svh"

module credit_counter (
  input  logic clk,
  input  logic reset,
  input  logic credit_return,
  input  logic send,
  output logic credit_avail
);

  localparam buffer_pkg::credit_t MAX_CREDITS = buffer_pkg::credit_t'(`BUF_DOWN_CREDITS);

  buffer_pkg::credit_t count_reg;
  buffer_pkg::credit_t count_next;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count_reg <= MAX_CREDITS;
    end else begin
      count_reg <= count_next;
    end
  end

  always_comb begin
    count_next = count_reg;
    case ({credit_return, send})
      2'b10: begin
        // A receiver never returns more than it was given
        if (count_reg != MAX_CREDITS) begin
          count_next = count_reg + 1'b1;
        end
      end
      2'b01: begin
        if (count_reg != '0) begin
          count_next = count_reg - 1'b1;
        end
      end
      default: begin
        // Return and send together cancel out
        count_next = count_reg;
      end
    endcase
  end

  assign credit_avail = (count_reg != '0);

endmodule

// ==== src/drain_ctrl.sv ====
// Drain FSM for the credit buffer
// Pops the FIFO whenever it holds a word and a downstream credit is available

`timescale 1ns/1ps

module drain_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic empty,
  input  logic credit_avail,
  output logic pop
);

  buffer_pkg::drain_state_e state_reg;
  buffer_pkg::drain_state_e state_next;

  // Send decision is combinational in the same cycle as the inputs
  assign pop = !empty && credit_avail;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_reg <= buffer_pkg::idle;
    end else begin
      state_reg <= state_next;
    end
  end

  // State shows the outcome of the last decision
  always_comb begin
    state_next = state_reg;
    case (state_reg)
      buffer_pkg::idle: begin
        if (!empty) begin
          if (credit_avail) begin
            state_next = buffer_pkg::send;
          end else begin
            state_next = buffer_pkg::wait_credit;
          end
        end
      end
      buffer_pkg::send: begin
        if (empty) begin
          state_next = buffer_pkg::idle;
        end else if (!credit_avail) begin
          // Downstream back-pressure
          state_next = buffer_pkg::wait_credit;
        end
      end
      buffer_pkg::wait_credit: begin
        if (empty) begin
          state_next = buffer_pkg::idle;
        end else if (credit_avail) begin
          state_next = buffer_pkg::send;
        end
      end
      default: begin
        state_next = buffer_pkg::idle;
      end
    endcase
  end

endmodule

// ==== src/credit_buffer_top.sv ====
// Credit-buffered word channel
// FIFO between two credit handshakes that a credit-gated FSM drains

`timescale 1ns/1ps

module credit_buffer_top (
  input  logic                  clk,
  input  logic                  reset,
  input  buffer_pkg::in_beat_t  in_beat,
  output logic                  in_credit,
  output buffer_pkg::out_beat_t out_beat,
  input  logic                  out_credit
);

  logic pop;
  logic empty;
  logic credit_avail;

  fifo fifo_i (
    .clk    (clk),
    .reset  (reset),
    .wr     (in_beat.valid),
    .w_data (in_beat.data),
    .rd     (pop),
    .r_beat (out_beat),
    .empty  (empty),
    .full   ()
  );

  credit_counter credit_counter_i (
    .clk           (clk),
    .reset         (reset),
    .credit_return (out_credit),
    .send          (pop),
    .credit_avail  (credit_avail)
  );

  drain_ctrl drain_ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .empty        (empty),
    .credit_avail (credit_avail),
    .pop          (pop)
  );

  // Each pop frees one FIFO entry, so it returns one upstream credit
  assign in_credit = pop;

endmodule

// ==== verif/fifo_properties.sv ====
// FIFO checker bound into the register-file FIFO
// Pointer protocol, flags against an occupancy model and data integrity

`timescale 1ns/1ps

`include "buffer_settings.svh"

module fifo_properties (
  input logic                  clk,
  input logic                  reset,
  input logic                  wr,
  input buffer_pkg::word_t     w_data,
  input logic                  rd,
  input buffer_pkg::out_beat_t r_beat,
  input buffer_pkg::ptr_t      w_ptr_reg,
  input buffer_pkg::ptr_t      r_ptr_reg,
  input logic                  full_reg,
  input logic                  empty_reg,
  input logic                  wr_en,
  input logic                  rd_en
);

  typedef logic [`BUF_ADDR_WIDTH:0] count_t;

  count_t            occupancy;
  buffer_pkg::word_t shadow [`BUF_DEPTH];
  buffer_pkg::word_t expected_data;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      occupancy <= '0;
    end else if (wr_en && !rd_en) begin
      occupancy <= occupancy + 1'b1;
    end else if (rd_en && !wr_en) begin
      occupancy <= occupancy - 1'b1;
    end
  end

  // Reference copy of each written word, read back on a pop
  always_ff @(posedge clk) begin
    if (wr_en) begin
      shadow[w_ptr_reg] <= w_data;
    end
    if (rd_en) begin
      expected_data <= shadow[r_ptr_reg];
    end
  end

  assert property (@(posedge clk) $past(reset) && reset |->
    (w_ptr_reg == '0 && r_ptr_reg == '0 && empty_reg && !full_reg && !r_beat.valid))
    else $error("fifo not in reset state while reset is held");

  assert property (@(posedge clk) disable iff (reset)
    empty_reg == (occupancy == '0) && full_reg == (occupancy == count_t'(`BUF_DEPTH)))
    else $error("fifo flags disagree with occupancy %0d", occupancy);

  assert property (@(posedge clk) disable iff (reset)
    wr_en |=> w_ptr_reg == buffer_pkg::ptr_t'($past(w_ptr_reg) + 1'b1))
    else $error("write pointer did not advance on an accepted write");

  assert property (@(posedge clk) disable iff (reset) !wr_en |=> $stable(w_ptr_reg))
    else $error("write pointer moved without an accepted write");

  assert property (@(posedge clk) disable iff (reset)
    rd_en |=> r_ptr_reg == buffer_pkg::ptr_t'($past(r_ptr_reg) + 1'b1))
    else $error("read pointer did not advance on an accepted read");

  assert property (@(posedge clk) disable iff (reset) !rd_en |=> $stable(r_ptr_reg))
    else $error("read pointer moved without an accepted read");

  assert property (@(posedge clk) disable iff (reset)
    wr && full_reg && !rd_en |=> $stable(w_ptr_reg) && full_reg && $stable(occupancy))
    else $error("write into a full fifo changed its state");

  assert property (@(posedge clk) disable iff (reset)
    rd && empty_reg && !wr_en |=> $stable(r_ptr_reg) && empty_reg && !r_beat.valid)
    else $error("read from an empty fifo changed its state");

  assert property (@(posedge clk) disable iff (reset)
    r_beat.valid |-> r_beat.data == expected_data)
    else $error("read data %h differs from written word %h", r_beat.data, expected_data);

endmodule

bind fifo fifo_properties fifo_properties_i (
  .clk       (clk),
  .reset     (reset),
  .wr        (wr),
  .w_data    (w_data),
  .rd        (rd),
  .r_beat    (r_beat),
  .w_ptr_reg (w_ptr_reg),
  .r_ptr_reg (r_ptr_reg),
  .full_reg  (full_reg),
  .empty_reg (empty_reg),
  .wr_en     (wr_en),
  .rd_en     (rd_en)
);

// ==== verif/credit_buffer_tb.sv ====
// Testbench for the credit-buffered word channel
// Replays the stimulus file, models both credit loops and checks word order

`timescale 1ns/1ps

`include "buffer_settings.svh"

module credit_buffer_tb;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 8;
  localparam string STIM_FILE = "verif/credit_buffer_stimulus.txt";

  logic                  clk;
  logic                  reset;
  buffer_pkg::in_beat_t  in_beat;
  logic                  in_credit;
  buffer_pkg::out_beat_t out_beat;
  logic                  out_credit;

  // Stimulus commands with one entry per file line
  byte   cmd_kind [$];
  string cmd_name [$];
  int    cmd_valid [$];
  int    cmd_data [$];
  int    cmd_credit [$];
  int    cmd_cycles [$];

  // Words written and not yet seen at the output
  buffer_pkg::word_t expected_words [$];

  integer seed;
  int     total_cycles;
  int     watchdog_ns;
  int     error_count;
  int     check_count;
  int     sends;
  int     returns_driven;
  int     returns_applied;
  int     in_credit_pulses;
  int     up_credits;
  int     test_errors_base;
  int     test_words;
  string  test_name;

  // Model of FIFO contents and of the drain decision
  int                       fifo_words;
  logic                     write_pending;
  buffer_pkg::drain_state_e state_expected;

  credit_buffer_top credit_buffer_top_i (
    .clk        (clk),
    .reset      (reset),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Watchdog armed once the stimulus length is known
  initial begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("timeout: stimulus did not complete within %0d ns", watchdog_ns);
    $display("Result: FAILED");
    $finish;
  end

  function automatic string strip_line(string s);
    string r;
    r = s;
    while (r.len() > 0 && (r.getc(r.len() - 1) == "\n" ||
           r.getc(r.len() - 1) == "\r" || r.getc(r.len() - 1) == " ")) begin
      r = r.substr(0, r.len() - 2);
    end
    return r;
  endfunction

  // Mode 0 is never, 1 is always and 2 is on random cycles
  function automatic logic pick(int mode);
    if (mode == 2) begin
      return ($random(seed) & 1) != 0;
    end
    return mode == 1;
  endfunction

  task automatic load_stimulus();
    int    fd;
    int    code;
    string line;
    int    v;
    int    d;
    int    c;
    int    n;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2) begin
        continue;
      end
      if (line.getc(0) == "T") begin
        cmd_kind.push_back("T");
        cmd_name.push_back(strip_line(line.substr(2, line.len() - 1)));
        cmd_valid.push_back(0);
        cmd_data.push_back(0);
        cmd_credit.push_back(0);
        cmd_cycles.push_back(0);
      end else if (line.getc(0) == "C") begin
        code = $sscanf(line.substr(2, line.len() - 1), "%d %h %d %d", v, d, c, n);
        if (code != 4) begin
          $display("malformed stimulus line: %s", strip_line(line));
          error_count++;
          continue;
        end
        cmd_kind.push_back("C");
        cmd_name.push_back("");
        cmd_valid.push_back(v);
        cmd_data.push_back(d);
        cmd_credit.push_back(c);
        cmd_cycles.push_back(n);
        total_cycles += n;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_word(buffer_pkg::word_t actual);
    buffer_pkg::word_t expected;
    check_count++;
    if (expected_words.size() == 0) begin
      $display("word %h appeared at %0t ns with no word outstanding", actual, $time);
      error_count++;
      return;
    end
    expected = expected_words.pop_front();
    if (actual !== expected) begin
      $display("mismatch at %0t ns: out_beat.data expected %h, got %h",
               $time, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_credit(buffer_pkg::credit_t actual);
    buffer_pkg::credit_t expected;
    expected = buffer_pkg::credit_t'(`BUF_DOWN_CREDITS - sends + returns_applied);
    check_count++;
    if (actual !== expected) begin
      $display("mismatch at %0t ns: credit_counter_i.count_reg expected %0d, got %0d",
               $time, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_state(buffer_pkg::drain_state_e actual);
    check_count++;
    if (actual !== state_expected) begin
      $display("mismatch at %0t ns: drain_ctrl_i.state_reg expected %s, got %s",
               $time, state_expected.name(), actual.name());
      error_count++;
    end
  endtask

  // Drives one clock cycle after the edge and samples at the falling edge
  task automatic run_cycle(int valid_mode, buffer_pkg::word_t data, int credit_mode);
    logic do_write;
    logic do_return;
    int   returns_prior;
    @(posedge clk);
    returns_prior = returns_applied;
    if (out_credit) begin
      returns_applied++;
    end
    // Last cycle's write and pop take effect at this edge
    if (write_pending) begin
      fifo_words++;
    end
    if (state_expected == buffer_pkg::send) begin
      fifo_words--;
    end
    #1;
    do_write = pick(valid_mode) && (up_credits > 0);
    // Receiver only returns credits for words it has taken
    do_return = pick(credit_mode) && (sends > returns_driven);
    in_beat.valid = do_write;
    in_beat.data = do_write ? data : '0;
    out_credit = do_return;
    write_pending = do_write;
    if (do_write) begin
      up_credits--;
      expected_words.push_back(data);
      test_words++;
    end
    if (do_return) begin
      returns_driven++;
    end
    @(negedge clk);
    if (in_credit) begin
      in_credit_pulses++;
      up_credits++;
      if (up_credits > `BUF_DEPTH) begin
        $display("upstream credit returned at %0t ns beyond the %0d issued",
                 $time, `BUF_DEPTH);
        error_count++;
      end
    end
    if (out_beat.valid) begin
      if (`BUF_DOWN_CREDITS - sends + returns_prior <= 0) begin
        $display("word sent at %0t ns without a downstream credit", $time);
        error_count++;
      end
      sends++;
      check_word(out_beat.data);
    end
    check_credit(credit_buffer_top_i.credit_counter_i.count_reg);
    check_state(credit_buffer_top_i.drain_ctrl_i.state_reg);
    // Drain decision of this cycle, shown by the state after the next edge
    if (fifo_words == 0) begin
      state_expected = buffer_pkg::idle;
    end else if (`BUF_DOWN_CREDITS - sends + returns_applied > 0) begin
      state_expected = buffer_pkg::send;
    end else begin
      state_expected = buffer_pkg::wait_credit;
    end
  endtask

  task automatic drain_remaining();
    while (expected_words.size() > 0 || returns_applied < sends) begin
      run_cycle(0, '0, 1);
    end
  endtask

  task automatic report_test();
    if (test_name != "") begin
      $display("test %s: %0d words, %0d errors", test_name, test_words,
               error_count - test_errors_base);
    end
  endtask

  initial begin
    reset = 1'b1;
    in_beat = '0;
    out_credit = 1'b0;
    seed = 32'hf5c34c36;
    total_cycles = 0;
    watchdog_ns = 0;
    error_count = 0;
    check_count = 0;
    sends = 0;
    returns_driven = 0;
    returns_applied = 0;
    in_credit_pulses = 0;
    up_credits = `BUF_DEPTH;
    test_errors_base = 0;
    test_words = 0;
    test_name = "";
    fifo_words = 0;
    write_pending = 1'b0;
    state_expected = buffer_pkg::idle;
    load_stimulus();
    watchdog_ns = (total_cycles + RESET_CYCLES) * CLK_PERIOD * 4;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    for (int i = 0; i < cmd_kind.size(); i++) begin
      if (cmd_kind[i] == "T") begin
        report_test();
        test_name = cmd_name[i];
        test_errors_base = error_count;
        test_words = 0;
      end else begin
        for (int k = 0; k < cmd_cycles[i]; k++) begin
          run_cycle(cmd_valid[i], buffer_pkg::word_t'(cmd_data[i] + k), cmd_credit[i]);
        end
      end
    end
    drain_remaining();
    report_test();
    if (in_credit_pulses != sends) begin
      $display("upstream credit pulses (%0d) differ from words sent (%0d)",
               in_credit_pulses, sends);
      error_count++;
    end
    if (up_credits != `BUF_DEPTH) begin
      $display("sender ends with %0d upstream credits instead of %0d",
               up_credits, `BUF_DEPTH);
      error_count++;
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/credit_buffer_stimulus.txt ====
# T <name> starts a test; C <in_valid> <in_data hex> <out_credit> <cycles>
# valid and credit: 0 off, 1 every cycle, 2 random; data counts up by one per cycle

T order
C 1 10 1 8
C 0 00 1 6

T credit_limit
# No credits returned, only the initial downstream credits are spent
C 1 40 0 8
C 0 00 0 4
C 0 00 1 14

T upstream_return
C 2 60 2 40
C 0 00 1 16

T backpressure
# Spend the downstream credits first
C 1 80 0 4
C 0 00 0 4
# Sixteen words fill the FIFO while credits are withheld
C 1 90 0 16
C 0 00 0 6
# Returning credits drains them in order
C 0 00 1 40

T wrap
C 1 00 1 64
C 0 00 1 12

T stream_random
C 2 a0 1 32
C 0 00 1 12

// ==== sources.f ====
+incdir+common
common/buffer_pkg.sv
fifo/fifo.sv
src/credit_counter.sv
src/drain_ctrl.sv
src/credit_buffer_top.sv
verif/fifo_properties.sv
verif/credit_buffer_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = credit_buffer_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
